// ==== Makefile ====
# Verilator flow for the equity counter

VERILATOR ?= verilator
TOP       ?= equity_tb
RTL_TOP   ?= equity_top
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_TEXT ?= TESTBENCH PASSED

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FLIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

// ==== flist.f ====
+incdir+logic
logic/card_pkg.sv
logic/bus_pkg.sv
logic/equity_regs.sv
logic/board_enumerator.sv
logic/hand_ranker.sv
logic/outcome_tally.sv
logic/equity_top.sv
sim/tb_clock.sv
sim/equity_tb.sv

// ==== logic/board_enumerator.sv ====
`timescale 1ns/1ns
`include "poker_consts.svh"

module board_enumerator import card_pkg::*;
(
	input  logic                     clock,
	input  logic                     rst_n,
	input  logic                     start,
	input  card_t [2*`N_PLAYERS-1:0] hole,
	input  card_t [2:0]              flop,
	output logic                     board_valid,
	output card_t                    turn,
	output card_t                    river,
	output logic                     enum_last, // Final scan step, board_valid may be low
	output logic                     cfg_error
);
	localparam int N_KNOWN  = 2*`N_PLAYERS + 3;
	localparam int LAST_IDX = `DECK_SIZE - 1;

	card_t [N_KNOWN-1:0]   known;
	logic [`DECK_SIZE-1:0] known_mask;
	logic [`DECK_SIZE-1:0] used; // Dead cards for this run
	logic                  bad_cfg;
	logic                  running;
	logic [5:0]            t_idx;
	logic [5:0]            r_idx;
	logic                  row_end;
	logic                  final_step;

	// Deck index to card, suit-major
	function automatic card_t idx_to_card(input logic [5:0] idx);
		card_t c;
		c.rank = rank_t'(idx % `N_RANKS);
		c.suit = suit_t'(idx / `N_RANKS);
		return c;
	endfunction

	// Card back to its deck index
	function automatic logic [5:0] card_to_idx(input card_t c);
		return 6'(c.suit * `N_RANKS + c.rank);
	endfunction

	assign known = {flop, hole};

	// Dead mask plus duplicate and range check
	always_comb
	begin
		known_mask = '0;
		bad_cfg    = 1'b0;
		for (int i = 0; i < N_KNOWN; i++)
		begin
			if (known[i].rank > RANK_ACE)
				bad_cfg = 1'b1;
			else
				known_mask[6'(known[i].suit * `N_RANKS + known[i].rank)] = 1'b1;
			for (int j = i + 1; j < N_KNOWN; j++)
				if (known[i] == known[j])
					bad_cfg = 1'b1;
		end
	end

	assign row_end    = used[t_idx] || r_idx == 6'(LAST_IDX); // Dead turn skips the row
	assign final_step = t_idx == 6'(LAST_IDX - 1); // Row 50 holds only river 51

	always_ff @(posedge clock)
	begin
		if (!rst_n)
		begin
			running     <= 1'b0;
			cfg_error   <= 1'b0;
			board_valid <= 1'b0;
			enum_last   <= 1'b0;
			t_idx       <= '0;
			r_idx       <= '0;
		end
		else if (start)
		begin
			cfg_error   <= bad_cfg;
			running     <= !bad_cfg; // Bad setup emits nothing
			board_valid <= 1'b0;
			enum_last   <= 1'b0;
			t_idx       <= 6'd0;
			r_idx       <= 6'd1;
		end
		else
		begin
			board_valid <= running && !used[t_idx] && !used[r_idx];
			enum_last   <= running && final_step;
			if (running)
			begin
				if (final_step)
					running <= 1'b0;
				else if (row_end)
				begin
					t_idx <= t_idx + 6'd1;
					r_idx <= t_idx + 6'd2;
				end
				else
					r_idx <= r_idx + 6'd1;
			end
		end
	end

	// Mask and board cards carry no reset
	always_ff @(posedge clock)
	begin
		if (start)
			used <= known_mask;
		turn  <= idx_to_card(t_idx);
		river <= idx_to_card(r_idx);
	end

	// Board cards are distinct and never dead
	assert property (@(posedge clock) disable iff (!rst_n)
		board_valid |-> turn != river && !used[card_to_idx(turn)] && !used[card_to_idx(river)]);
	assert property (@(posedge clock) disable iff (!rst_n)
		cfg_error |-> !board_valid);

endmodule

// ==== logic/bus_pkg.sv ====
`include "poker_consts.svh"

package bus_pkg;

	// AXI response codes in use
	typedef enum logic [1:0] {
		RESP_OKAY   = 2'b00,
		RESP_SLVERR = 2'b10
	} resp_e;

	// Word index, address bits above the byte offset
	typedef enum logic [2:0] {
		IDX_CTRL   = 3'(`REG_CTRL >> 2),
		IDX_STATUS = 3'(`REG_STATUS >> 2),
		IDX_HOLE   = 3'(`REG_HOLE >> 2),
		IDX_FLOP   = 3'(`REG_FLOP >> 2),
		IDX_WIN    = 3'(`REG_WIN >> 2),
		IDX_TIE    = 3'(`REG_TIE >> 2),
		IDX_LOSS   = 3'(`REG_LOSS >> 2),
		IDX_BOARDS = 3'(`REG_BOARDS >> 2)
	} reg_addr_e;

	// One byte lane, card in the low six bits
	typedef struct packed {
		logic [1:0]       pad;
		card_pkg::card_t  card;
	} lane_t;

	// HOLE and FLOP word, bus view or card lanes
	typedef union packed {
		logic [`DATA_W-1:0] raw;
		lane_t [3:0]        lane;
	} cfg_word_u;

endpackage

// ==== logic/card_pkg.sv ====
`include "poker_consts.svh"

package card_pkg;

	// Rank code 0 is a deuce, 12 the ace
	typedef logic [3:0] rank_t;
	typedef logic [1:0] suit_t;

	localparam rank_t RANK_ACE = rank_t'(`N_RANKS - 1); // Anything above is invalid
	localparam rank_t RANK_FIVE = rank_t'(3); // Top of the wheel

	// Six-bit card code
	typedef struct packed {
		suit_t suit;
		rank_t rank;
	} card_t;

	// Weakest first, so the code itself orders hands
	typedef enum logic [2:0] {
		CAT_HIGH       = 3'd0,
		CAT_PAIR       = 3'd1,
		CAT_TWO_PAIR   = 3'd2,
		CAT_TRIPS      = 3'd3,
		CAT_STRAIGHT   = 3'd4,
		CAT_FLUSH      = 3'd5,
		CAT_FULL_HOUSE = 3'd6,
		CAT_QUADS      = 3'd7
	} category_e;

	// Category on top, unsigned compare ranks two hands
	typedef struct packed {
		category_e category;
		rank_t     primary;
	} strength_t;

endpackage

// ==== logic/equity_regs.sv ====
`timescale 1ns/1ns
`include "poker_consts.svh"

module equity_regs import card_pkg::*, bus_pkg::*;
(
	input  logic                        clock,
	input  logic                        rst_n,
	input  logic                        awvalid,
	output logic                        awready,
	input  logic [`ADDR_W-1:0]          awaddr,
	input  logic                        wvalid,
	output logic                        wready,
	input  logic [`DATA_W-1:0]          wdata,
	output logic                        bvalid,
	input  logic                        bready,
	output resp_e                       bresp,
	input  logic                        arvalid,
	output logic                        arready,
	input  logic [`ADDR_W-1:0]          araddr,
	output logic                        rvalid,
	input  logic                        rready,
	output logic [`DATA_W-1:0]          rdata,
	output resp_e                       rresp,
	input  logic                        done,
	input  logic                        cfg_error,
	input  logic [`CNT_W-1:0]           win_count,
	input  logic [`CNT_W-1:0]           tie_count,
	input  logic [`CNT_W-1:0]           loss_count,
	input  logic [`CNT_W-1:0]           board_count,
	output logic                        start,
	output card_t [2*`N_PLAYERS-1:0]    hole,
	output card_t [2:0]                 flop
);
	cfg_word_u          hole_q;
	cfg_word_u          flop_q;
	logic               busy;
	logic               done_flag;
	logic               err_flag;
	logic               wr_hs; // Address and data accepted together
	logic               wr_ok;
	logic               rd_hs;
	logic               rd_ok;
	reg_addr_e          wr_idx;
	reg_addr_e          rd_idx;
	logic [`DATA_W-1:0] rd_word;

	assign wr_hs   = awvalid && wvalid && !bvalid;
	assign awready = wr_hs;
	assign wready  = wr_hs;
	assign arready = !rvalid; // Free while no read response waits
	assign rd_hs   = arvalid && arready;

	assign wr_idx = reg_addr_e'(awaddr[`ADDR_W-1:2]);
	assign rd_idx = reg_addr_e'(araddr[`ADDR_W-1:2]);
	assign rd_ok  = araddr[1:0] == 2'b00; // Unaligned counts as unmapped

	// Only CTRL, HOLE and FLOP take writes, and never mid-run
	assign wr_ok = awaddr[1:0] == 2'b00 && !busy
		&& (wr_idx inside {IDX_CTRL, IDX_HOLE, IDX_FLOP});

	// Card lanes out to the datapath
	for (genvar i = 0; i < 2*`N_PLAYERS; i++)
	begin : g_hole
		assign hole[i] = hole_q.lane[i].card;
	end
	for (genvar i = 0; i < 3; i++)
	begin : g_flop
		assign flop[i] = flop_q.lane[i].card; // Lane 3 ignored
	end

	// Handshakes and run status
	always_ff @(posedge clock)
	begin
		if (!rst_n)
		begin
			bvalid    <= 1'b0;
			rvalid    <= 1'b0;
			start     <= 1'b0;
			busy      <= 1'b0;
			done_flag <= 1'b0;
			err_flag  <= 1'b0;
		end
		else
		begin
			start <= 1'b0;
			if (wr_hs)
				bvalid <= 1'b1;
			else if (bready)
				bvalid <= 1'b0;
			if (rd_hs)
				rvalid <= 1'b1;
			else if (rready)
				rvalid <= 1'b0;
			if (wr_hs && wr_ok && wr_idx == IDX_CTRL && wdata[0])
			begin
				start     <= 1'b1; // Pulse lands next cycle
				busy      <= 1'b1;
				done_flag <= 1'b0;
				err_flag  <= 1'b0;
			end
			else
			begin
				if (done)
					busy <= 1'b0;
				done_flag <= done_flag || done;
				if (!start)
					err_flag <= err_flag || cfg_error; // Stale during start cycle
			end
		end
	end

	// Config words and response payload
	always_ff @(posedge clock)
	begin
		if (wr_hs)
			bresp <= wr_ok ? RESP_OKAY : RESP_SLVERR;
		if (wr_hs && wr_ok && wr_idx == IDX_HOLE)
			hole_q.raw <= wdata;
		if (wr_hs && wr_ok && wr_idx == IDX_FLOP)
			flop_q.raw <= wdata;
		if (rd_hs)
		begin
			rdata <= rd_word;
			rresp <= rd_ok ? RESP_OKAY : RESP_SLVERR;
		end
	end

	// Read mux, zero for CTRL and unmapped
	always_comb
	begin
		rd_word = '0;
		if (rd_ok)
			case (rd_idx)
				IDX_STATUS: rd_word = `DATA_W'({err_flag, done_flag, busy});
				IDX_HOLE:   rd_word = hole_q.raw;
				IDX_FLOP:   rd_word = flop_q.raw;
				IDX_WIN:    rd_word = `DATA_W'(win_count);
				IDX_TIE:    rd_word = `DATA_W'(tie_count);
				IDX_LOSS:   rd_word = `DATA_W'(loss_count);
				IDX_BOARDS: rd_word = `DATA_W'(board_count);
				default:    rd_word = '0;
			endcase
	end

	// Responses hold still until taken
	assert property (@(posedge clock) disable iff (!rst_n)
		bvalid && !bready |=> bvalid && $stable(bresp));
	assert property (@(posedge clock) disable iff (!rst_n)
		rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp));

endmodule

// ==== logic/equity_top.sv ====
`timescale 1ns/1ns
`include "poker_consts.svh"

module equity_top import card_pkg::*, bus_pkg::*;
(
	input  logic               clock,
	input  logic               rst_n,
	input  logic               awvalid,
	output logic               awready,
	input  logic [`ADDR_W-1:0] awaddr,
	input  logic               wvalid,
	output logic               wready,
	input  logic [`DATA_W-1:0] wdata,
	output logic               bvalid,
	input  logic               bready,
	output resp_e              bresp,
	input  logic               arvalid,
	output logic               arready,
	input  logic [`ADDR_W-1:0] araddr,
	output logic               rvalid,
	input  logic               rready,
	output logic [`DATA_W-1:0] rdata,
	output resp_e              rresp
);
	logic                       start;
	logic                       done;
	logic                       cfg_error;
	logic                       board_valid;
	logic                       score_valid;
	logic                       enum_last;
	card_t [2*`N_PLAYERS-1:0]   hole;
	card_t [2:0]                flop;
	card_t                      turn;
	card_t                      river;
	strength_t [`N_PLAYERS-1:0] strength;
	logic [`CNT_W-1:0]          win_count;
	logic [`CNT_W-1:0]          tie_count;
	logic [`CNT_W-1:0]          loss_count;
	logic [`CNT_W-1:0]          board_count;

	equity_regs i_regs (.*); // Host side

	board_enumerator i_enum
	(
		.clock       (clock),
		.rst_n       (rst_n),
		.start       (start),
		.hole        (hole),
		.flop        (flop),
		.board_valid (board_valid),
		.turn        (turn),
		.river       (river),
		.enum_last   (enum_last),
		.cfg_error   (cfg_error)
	);

	// Same board, each player's own hole pair
	for (genvar p = 0; p < `N_PLAYERS; p++)
	begin : g_rank
		hand_ranker i_ranker
		(
			.clock       (clock),
			.rst_n       (rst_n),
			.hole_pair   (hole[2*p +: 2]),
			.flop        (flop),
			.turn        (turn),
			.river       (river),
			.board_valid (board_valid),
			.strength    (strength[p])
		);
	end

	// Valid follows the ranker register
	always_ff @(posedge clock)
	begin
		if (!rst_n)
			score_valid <= 1'b0;
		else
			score_valid <= board_valid;
	end

	outcome_tally i_tally (.*);

endmodule

// ==== logic/hand_ranker.sv ====
`timescale 1ns/1ns
`include "poker_consts.svh"

module hand_ranker import card_pkg::*;
(
	input  logic        clock,
	input  logic        rst_n,
	input  card_t [1:0] hole_pair,
	input  card_t [2:0] flop,
	input  card_t       turn,
	input  card_t       river,
	input  logic        board_valid,
	output strength_t   strength
);
	card_t [6:0]         cards;
	logic [2:0]          hist [`N_RANKS]; // Cards per rank
	logic [2:0]          suit_cnt [`N_SUITS];
	logic [`N_RANKS-1:0] present;
	logic [`N_RANKS-1:0] flush_mask; // Ranks held in the flush suit
	suit_t               flush_suit;
	logic                flush;
	logic                has_quad;
	logic                has_trip;
	logic                has_trip2;
	logic                has_pair;
	logic                has_pair2;
	logic                straight;
	rank_t               quad_r;
	rank_t               trip_r;
	rank_t               pair_r;
	rank_t               straight_r;
	rank_t               high_r;
	rank_t               flush_r;
	strength_t           next_strength;

	assign cards = {river, turn, flop, hole_pair};

	// Rank histogram and suit counts
	always_comb
	begin
		for (int r = 0; r < `N_RANKS; r++)
			hist[r] = 3'd0;
		for (int s = 0; s < `N_SUITS; s++)
			suit_cnt[s] = 3'd0;
		present = '0;
		for (int i = 0; i < 7; i++)
		begin
			hist[cards[i].rank]     = hist[cards[i].rank] + 3'd1;
			suit_cnt[cards[i].suit] = suit_cnt[cards[i].suit] + 3'd1;
			present[cards[i].rank]  = 1'b1;
		end
	end

	// At most one suit reaches five of seven
	always_comb
	begin
		flush      = 1'b0;
		flush_suit = '0;
		flush_mask = '0;
		for (int s = 0; s < `N_SUITS; s++)
			if (suit_cnt[s] >= 3'd5)
			begin
				flush      = 1'b1;
				flush_suit = suit_t'(s);
			end
		for (int i = 0; i < 7; i++)
			if (cards[i].suit == flush_suit)
				flush_mask[cards[i].rank] = 1'b1;
	end

	// Groups, straights and highs, low to high so the last hit is the top one
	always_comb
	begin
		has_quad   = 1'b0;
		has_trip   = 1'b0;
		has_trip2  = 1'b0;
		has_pair   = 1'b0;
		has_pair2  = 1'b0;
		straight   = 1'b0;
		quad_r     = '0;
		trip_r     = '0;
		pair_r     = '0;
		straight_r = '0;
		high_r     = '0;
		flush_r    = '0;
		for (int r = 0; r < `N_RANKS; r++)
		begin
			if (present[r])
				high_r = rank_t'(r);
			if (flush_mask[r])
				flush_r = rank_t'(r);
			case (hist[r])
				3'd4:
				begin
					has_quad = 1'b1;
					quad_r   = rank_t'(r);
				end
				3'd3:
				begin
					has_trip2 = has_trip; // Lower trips act as the pair
					has_trip  = 1'b1;
					trip_r    = rank_t'(r);
				end
				3'd2:
				begin
					has_pair2 = has_pair;
					has_pair  = 1'b1;
					pair_r    = rank_t'(r);
				end
				default: ;
			endcase
		end
		if (present[RANK_ACE] && &present[3:0])
		begin
			straight   = 1'b1; // Wheel, five-high
			straight_r = RANK_FIVE;
		end
		for (int t = 4; t < `N_RANKS; t++)
			if (&present[t -: 5])
			begin
				straight   = 1'b1;
				straight_r = rank_t'(t);
			end
	end

	// Strongest category wins, straight flush counts as a flush
	always_comb
	begin
		if (has_quad)
			next_strength = '{CAT_QUADS, quad_r};
		else if (has_trip && (has_pair || has_trip2))
			next_strength = '{CAT_FULL_HOUSE, trip_r};
		else if (flush)
			next_strength = '{CAT_FLUSH, flush_r};
		else if (straight)
			next_strength = '{CAT_STRAIGHT, straight_r};
		else if (has_trip)
			next_strength = '{CAT_TRIPS, trip_r};
		else if (has_pair2)
			next_strength = '{CAT_TWO_PAIR, pair_r}; // Higher pair
		else if (has_pair)
			next_strength = '{CAT_PAIR, pair_r};
		else
			next_strength = '{CAT_HIGH, high_r};
	end

	always_ff @(posedge clock)
	begin
		if (!rst_n)
			strength <= '0;
		else if (board_valid)
			strength <= next_strength; // One cycle behind the board
	end

	// Primary rank is always one the hand holds
	assert property (@(posedge clock) disable iff (!rst_n)
		board_valid |-> present[next_strength.primary]);

endmodule

// ==== logic/outcome_tally.sv ====
`timescale 1ns/1ns
`include "poker_consts.svh"

module outcome_tally import card_pkg::*;
(
	input  logic                          clock,
	input  logic                          rst_n,
	input  logic                          start,
	input  strength_t [`N_PLAYERS-1:0]    strength,
	input  logic                          score_valid, // board_valid one cycle late
	input  logic                          enum_last,
	input  logic                          cfg_error,
	output logic [`CNT_W-1:0]             win_count,
	output logic [`CNT_W-1:0]             tie_count,
	output logic [`CNT_W-1:0]             loss_count,
	output logic [`CNT_W-1:0]             board_count,
	output logic                          done
);
	logic       last_d; // Lines up with score_valid
	logic       done_q;
	logic       err_seen;
	logic [6:0] p1;
	logic [6:0] p2;

	assign p1 = strength[0];
	assign p2 = strength[1];

	always_ff @(posedge clock)
	begin
		if (!rst_n)
		begin
			last_d      <= 1'b0;
			done_q      <= 1'b0;
			err_seen    <= 1'b0;
			win_count   <= '0;
			tie_count   <= '0;
			loss_count  <= '0;
			board_count <= '0;
		end
		else
		begin
			last_d   <= enum_last && !start;
			done_q   <= last_d; // Last board counted this edge
			err_seen <= start ? 1'b0 : cfg_error;
			if (start)
			begin
				win_count   <= '0;
				tie_count   <= '0;
				loss_count  <= '0;
				board_count <= '0;
			end
			else if (score_valid)
			begin
				board_count <= board_count + 1'b1;
				if (p1 > p2)
					win_count <= win_count + 1'b1;
				else if (p1 == p2)
					tie_count <= tie_count + 1'b1; // Kickers ignored
				else
					loss_count <= loss_count + 1'b1;
			end
		end
	end

	// Drain pulse, or first cycle of a bad setup
	assign done = done_q || (cfg_error && !err_seen);

	// Bad setup scores no boards
	assert property (@(posedge clock) disable iff (!rst_n)
		cfg_error |-> board_count == '0);

endmodule

// ==== logic/poker_consts.svh ====
`ifndef POKER_CONSTS_SVH
`define POKER_CONSTS_SVH

// Table size, heads-up only
`define N_PLAYERS 2

// Deck geometry
`define N_RANKS   13
`define N_SUITS   4
`define DECK_SIZE 52

`define CNT_W  16 // Enough for 990 boards with headroom
`define ADDR_W 5  // Eight word registers
`define DATA_W 32

// Register byte offsets
`define REG_CTRL   5'h00
`define REG_STATUS 5'h04
`define REG_HOLE   5'h08
`define REG_FLOP   5'h0C
`define REG_WIN    5'h10
`define REG_TIE    5'h14
`define REG_LOSS   5'h18
`define REG_BOARDS 5'h1C

`endif

// ==== sim/equity_tb.sv ====
`timescale 1ns/1ns
`include "poker_consts.svh"

module equity_tb import bus_pkg::*;
();
	localparam int N_RUNS        = 6;    // Fixed, three random, bad setup, busy run
	localparam int RUN_CYCLES    = 1400; // Full scan plus pipeline drain
	localparam int BUS_CYCLES    = 1600; // Config writes, count reads, polling
	localparam int MARGIN        = 10000;
	localparam int TIMEOUT_CYCLES = N_RUNS * RUN_CYCLES + BUS_CYCLES + MARGIN;
	localparam int N_BOARDS      = 990; // 45 choose 2
	localparam int SETTLE        = 1;   // Into the low phase, ready settled from new valids

	logic               clock;
	logic               rst_n;
	logic               awvalid;
	logic               awready;
	logic [`ADDR_W-1:0] awaddr;
	logic               wvalid;
	logic               wready;
	logic [`DATA_W-1:0] wdata;
	logic               bvalid;
	logic               bready;
	resp_e              bresp;
	logic               arvalid;
	logic               arready;
	logic [`ADDR_W-1:0] araddr;
	logic               rvalid;
	logic               rready;
	logic [`DATA_W-1:0] rdata;
	resp_e              rresp;

	string       cur_test = "reset";
	int          test_errs = 0;
	int          total_errs = 0;
	int          tests_run = 0;
	int          tests_failed = 0;
	int          cycles = 0;
	logic [15:0] lfsr = 16'd27;
	int          fixed_cards [7] = '{12, 25, 37, 50, 0, 18, 33}; // AA, KK, flop 2 7 9

	tb_clock i_clock (.clock(clock), .rst_n(rst_n));

	equity_top i_dut (.*);

	// Hang guard
	always @(posedge clock)
	begin
		cycles = cycles + 1;
		if (cycles >= TIMEOUT_CYCLES)
		begin
			$display("Timeout after %0d cycles, test %s never finished", cycles, cur_test);
			$display("TESTBENCH FAILED");
			$finish;
		end
	end

	// x^16 + x^14 + x^13 + x^11 + 1, one bit out per step
	function automatic logic lfsr_bit();
		logic out;
		logic fb;
		out  = lfsr[15];
		fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
		lfsr = {lfsr[14:0], fb};
		return out;
	endfunction

	// Deck index to 6-bit code, suit above rank
	function automatic logic [5:0] card_code(input int idx);
		return {2'(idx / 13), 4'(idx % 13)};
	endfunction

	function automatic logic [31:0] hole_word(input int k [7]);
		return {2'b00, card_code(k[3]), 2'b00, card_code(k[2]),
			2'b00, card_code(k[1]), 2'b00, card_code(k[0])};
	endfunction

	function automatic logic [31:0] flop_word(input int k [7]);
		return {8'h00, 2'b00, card_code(k[6]), 2'b00, card_code(k[5]),
			2'b00, card_code(k[4])};
	endfunction

	// Reference strength, category * 16 + primary rank
	function automatic int hand_value(input int c [7]);
		int   cnt [13];
		int   scnt [4];
		int   quad;
		int   trip;
		int   extra;
		int   p1;
		int   p2;
		int   hi;
		int   fs;
		int   fhi;
		int   st;
		int   rr;
		logic ok;
		quad  = -1;
		trip  = -1;
		extra = -1; // Second trips, plays as the pair
		p1    = -1;
		p2    = -1;
		hi    = -1;
		fs    = -1;
		fhi   = -1;
		st    = -1;
		for (int r = 0; r < 13; r++)
			cnt[r] = 0;
		for (int s = 0; s < 4; s++)
			scnt[s] = 0;
		for (int i = 0; i < 7; i++)
		begin
			cnt[c[i] % 13]++;
			scnt[c[i] / 13]++;
		end
		for (int s = 0; s < 4; s++)
			if (scnt[s] >= 5)
				fs = s;
		// Top down, first hit is the highest
		for (int r = 12; r >= 0; r--)
		begin
			if (cnt[r] == 4 && quad < 0)
				quad = r;
			if (cnt[r] == 3)
			begin
				if (trip < 0)
					trip = r;
				else if (extra < 0)
					extra = r;
			end
			if (cnt[r] == 2)
			begin
				if (p1 < 0)
					p1 = r;
				else if (p2 < 0)
					p2 = r;
			end
			if (cnt[r] > 0 && hi < 0)
				hi = r;
		end
		for (int i = 0; i < 7; i++)
			if (fs >= 0 && c[i] / 13 == fs && c[i] % 13 > fhi)
				fhi = c[i] % 13;
		// Five in a row, ace wraps below the deuce
		for (int top = 12; top >= 3; top--)
		begin
			ok = 1'b1;
			for (int k = 0; k < 5; k++)
			begin
				rr = top - k;
				if (rr < 0)
					rr = 12;
				if (cnt[rr] == 0)
					ok = 1'b0;
			end
			if (ok && st < 0)
				st = top;
		end
		if (quad >= 0)
			return 7 * 16 + quad;
		else if (trip >= 0 && (p1 >= 0 || extra >= 0))
			return 6 * 16 + trip;
		else if (fs >= 0)
			return 5 * 16 + fhi;
		else if (st >= 0)
			return 4 * 16 + st;
		else if (trip >= 0)
			return 3 * 16 + trip;
		else if (p2 >= 0)
			return 2 * 16 + p1;
		else if (p1 >= 0)
			return 16 + p1;
		else
			return hi;
	endfunction

	// Every open turn and river, scored from player 1's side
	function automatic void model_counts(input int k [7], output int win, output int tie,
		output int loss, output int boards);
		logic used [52];
		int   a [7];
		int   b [7];
		int   va;
		int   vb;
		win    = 0;
		tie    = 0;
		loss   = 0;
		boards = 0;
		for (int i = 0; i < 52; i++)
			used[i] = 1'b0;
		for (int i = 0; i < 7; i++)
			used[k[i]] = 1'b1;
		a = '{k[0], k[1], k[4], k[5], k[6], 0, 0};
		b = '{k[2], k[3], k[4], k[5], k[6], 0, 0};
		for (int t = 0; t < 51; t++)
			for (int r = t + 1; r < 52; r++)
				if (!used[t] && !used[r])
				begin
					a[5] = t;
					a[6] = r;
					b[5] = t;
					b[6] = r;
					va = hand_value(a);
					vb = hand_value(b);
					boards++;
					if (va > vb)
						win++;
					else if (va == vb)
						tie++; // Kickers ignored
					else
						loss++;
				end
	endfunction

	task automatic check_value(input string what, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual)
		begin
			$display("[ERROR] %s %s: expected %0d, actual %0d", cur_test, what, expected, actual);
			test_errs++;
			total_errs++;
		end
	endtask

	task automatic start_test(input string name);
		cur_test  = name;
		test_errs = 0;
	endtask

	task automatic finish_test();
		tests_run++;
		if (test_errs != 0)
		begin
			tests_failed++;
			$display("%s: failed with %0d errors", cur_test, test_errs);
		end
		else
			$display("%s: ok", cur_test);
	endtask

	// Write, bready held low for stall cycles once bvalid shows
	task automatic axi_write(input logic [`ADDR_W-1:0] addr, input logic [31:0] data,
		input int stall, output resp_e resp);
		@(negedge clock);
		awaddr  = addr;
		wdata   = data;
		awvalid = 1'b1;
		wvalid  = 1'b1;
		bready  = 1'b0;
		#SETTLE;
		check_value("awready", 32'(1), 32'(awready)); // No response pending
		check_value("wready", 32'(1), 32'(wready));
		@(negedge clock);
		while (!bvalid)
			@(negedge clock);
		awvalid = 1'b0; // Accepted on the edge that raised bvalid
		wvalid  = 1'b0;
		resp    = bresp;
		repeat (stall)
		begin
			@(negedge clock);
			check_value("bvalid held", 32'(1), 32'(bvalid));
			check_value("bresp stable", 32'(resp), 32'(bresp));
		end
		bready = 1'b1;
		@(negedge clock);
		bready = 1'b0;
	endtask

	task automatic axi_read(input logic [`ADDR_W-1:0] addr, input int stall,
		output logic [31:0] data, output resp_e resp);
		@(negedge clock);
		check_value("arready", 32'(1), 32'(arready)); // Idle read channel
		araddr  = addr;
		arvalid = 1'b1;
		rready  = 1'b0;
		@(negedge clock);
		while (!rvalid)
			@(negedge clock);
		arvalid = 1'b0;
		data    = rdata;
		resp    = rresp;
		repeat (stall)
		begin
			@(negedge clock);
			check_value("rvalid held", 32'(1), 32'(rvalid));
			check_value("arready low", 32'(0), 32'(arready));
			check_value("rdata stable", data, rdata);
			check_value("rresp stable", 32'(resp), 32'(rresp));
		end
		rready = 1'b1;
		@(negedge clock);
		rready = 1'b0;
	endtask

	// Poll STATUS until the sticky done bit, busy must show meanwhile
	task automatic wait_done();
		logic [31:0] st;
		resp_e       rs;
		st = '0;
		while (!st[1])
		begin
			axi_read(`REG_STATUS, 0, st, rs);
			if (!st[1])
				check_value("STATUS busy", 32'd1, 32'(st[0]));
		end
	endtask

	task automatic read_check(input logic [`ADDR_W-1:0] addr, input string what,
		input logic [31:0] expected);
		logic [31:0] data;
		resp_e       rs;
		axi_read(addr, 0, data, rs);
		check_value(what, expected, data);
		check_value({what, " resp"}, 32'(RESP_OKAY), 32'(rs));
	endtask

	// Load a hand, run it, compare against the model
	task automatic run_and_check(input int k [7]);
		resp_e       rs;
		logic [31:0] w;
		logic [31:0] t;
		logic [31:0] l;
		logic [31:0] n;
		int          ew;
		int          et;
		int          el;
		int          en;
		model_counts(k, ew, et, el, en);
		axi_write(`REG_HOLE, hole_word(k), 0, rs);
		check_value("HOLE write resp", 32'(RESP_OKAY), 32'(rs));
		axi_write(`REG_FLOP, flop_word(k), 0, rs);
		check_value("FLOP write resp", 32'(RESP_OKAY), 32'(rs));
		axi_write(`REG_CTRL, 32'd1, 0, rs);
		check_value("CTRL write resp", 32'(RESP_OKAY), 32'(rs));
		wait_done();
		read_check(`REG_STATUS, "STATUS", 32'd2); // Done only
		axi_read(`REG_WIN, 0, w, rs);
		axi_read(`REG_TIE, 0, t, rs);
		axi_read(`REG_LOSS, 0, l, rs);
		axi_read(`REG_BOARDS, 0, n, rs);
		check_value("WIN", ew, w);
		check_value("TIE", et, t);
		check_value("LOSS", el, l);
		check_value("BOARDS", en, n);
		check_value("count sum", N_BOARDS, w + t + l);
	endtask

	task automatic after_reset_test();
		start_test("after_reset");
		read_check(`REG_STATUS, "STATUS", 32'd0);
		read_check(`REG_WIN, "WIN", 32'd0);
		read_check(`REG_TIE, "TIE", 32'd0);
		read_check(`REG_LOSS, "LOSS", 32'd0);
		read_check(`REG_BOARDS, "BOARDS", 32'd0);
		begin
			resp_e rs;
			axi_write(`REG_HOLE, 32'hA5C3_1E07, 0, rs);
			axi_write(`REG_FLOP, 32'h5A3C_E1F8, 0, rs);
		end
		read_check(`REG_HOLE, "HOLE readback", 32'hA5C3_1E07); // Raw word, pad bits too
		read_check(`REG_FLOP, "FLOP readback", 32'h5A3C_E1F8);
		finish_test();
	endtask

	task automatic fixed_hand_test();
		start_test("fixed_hand");
		run_and_check(fixed_cards);
		finish_test();
	endtask

	// Seven distinct cards, six LFSR bits each, redraw on a miss
	task automatic random_hand_test(input int run);
		int   k [7];
		int   idx;
		logic taken [52];
		start_test($sformatf("random_hand_%0d", run));
		for (int i = 0; i < 52; i++)
			taken[i] = 1'b0;
		for (int i = 0; i < 7; i++)
		begin
			idx = 52;
			while (idx >= 52 || taken[idx])
			begin
				idx = 0;
				for (int b = 0; b < 6; b++)
					idx = (idx << 1) | int'(lfsr_bit());
			end
			taken[idx] = 1'b1;
			k[i] = idx;
		end
		run_and_check(k);
		finish_test();
	endtask

	task automatic bad_config_test();
		int    k [7];
		resp_e rs;
		start_test("bad_config");
		k    = fixed_cards;
		k[5] = k[4]; // Flop card repeated
		axi_write(`REG_HOLE, hole_word(k), 0, rs);
		axi_write(`REG_FLOP, flop_word(k), 0, rs);
		axi_write(`REG_CTRL, 32'd1, 0, rs);
		wait_done();
		read_check(`REG_STATUS, "STATUS", 32'd6); // Error and done, not busy
		read_check(`REG_BOARDS, "BOARDS", 32'd0);
		finish_test();
	endtask

	task automatic bus_error_test();
		logic [31:0] data;
		logic [31:0] hw;
		resp_e       rs;
		start_test("bus_errors");
		axi_read(5'h05, 0, data, rs); // Unaligned, no register there
		check_value("unmapped resp", 32'(RESP_SLVERR), 32'(rs));
		check_value("unmapped data", 32'd0, data);
		hw = hole_word(fixed_cards);
		axi_write(`REG_HOLE, hw, 5, rs);
		check_value("stalled write resp", 32'(RESP_OKAY), 32'(rs));
		axi_read(`REG_HOLE, 5, data, rs);
		check_value("stalled read data", hw, data);
		axi_write(`REG_FLOP, flop_word(fixed_cards), 0, rs);
		axi_write(`REG_CTRL, 32'd1, 0, rs);
		axi_write(`REG_HOLE, 32'h0000_0000, 0, rs); // Lands mid-run
		check_value("busy write resp", 32'(RESP_SLVERR), 32'(rs));
		wait_done();
		read_check(`REG_HOLE, "HOLE after busy write", hw);
		finish_test();
	endtask

	initial
	begin
		awvalid = 1'b0;
		awaddr  = '0;
		wvalid  = 1'b0;
		wdata   = '0;
		bready  = 1'b0;
		arvalid = 1'b0;
		araddr  = '0;
		rready  = 1'b0;
		wait (rst_n === 1'b1);
		after_reset_test();
		fixed_hand_test();
		for (int run = 1; run <= 3; run++)
			random_hand_test(run);
		bad_config_test();
		bus_error_test();
		$display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, total_errs);
		if (total_errs == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

// ==== sim/tb_clock.sv ====
`timescale 1ns/1ns

module tb_clock #(
	parameter int HALF_PERIOD  = 2,  // 4 ns clock
	parameter int RESET_CYCLES = 10
)
(
	output logic clock,
	output logic rst_n
);
	initial
	begin
		clock = 1'b0;
		forever #HALF_PERIOD clock = ~clock;
	end

	// Release on a falling edge, away from the sampling edge
	initial
	begin
		rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clock);
		@(negedge clock);
		rst_n = 1'b1;
	end

endmodule
